/* src/btb_pkg.sv */
package btb_pkg;

    // address path widths
    localparam int addr_w = 32;           // eip, fip and target width
    localparam int index_w = 6;           // eip[5:0] selects the line
    localparam int tag_w = addr_w - index_w; // eip[31:6], 26 bits

    // storage sizes
    localparam int btb_lines = 1 << index_w; // 64 lines, direct mapped
    localparam int queue_depth = 4;          // pending writeback updates

    // update queue pointer and count widths
    localparam int qptr_w = $clog2(queue_depth);     // head/tail pointer
    localparam int qcnt_w = $clog2(queue_depth + 1); // occupancy 0..4

    // owner of the single array port in the current cycle
    typedef enum logic [1:0] {
        grant_none,   // port idle
        grant_lookup, // fetch side reads the indexed line
        grant_update  // writeback side writes the indexed line
    } grant_e;

endpackage

/* src/btb_port_if.sv */
interface btb_port_if import btb_pkg::*; ();

    // requester side
    logic              req;     // level, held while access is wanted
    logic              we;      // write request when set
    logic [index_w-1:0] index;
    logic [tag_w-1:0]   tag;
    logic [addr_w-1:0]  wtarget;
    logic [addr_w-1:0]  wfip_e;
    logic [addr_w-1:0]  wfip_o;

    // arbiter side, valid in the same cycle as gnt
    logic              gnt;
    logic              hit;
    logic [addr_w-1:0]  rtarget;
    logic [addr_w-1:0]  rfip_e;
    logic [addr_w-1:0]  rfip_o;

    modport requester (
        output req, we, index, tag, wtarget, wfip_e, wfip_o,
        input  gnt, hit, rtarget, rfip_e, rfip_o
    );

    modport arbiter (
        input  req, we, index, tag, wtarget, wfip_e, wfip_o,
        output gnt, hit, rtarget, rfip_e, rfip_o
    );

endinterface

/* src/btb_array.sv */
module btb_array import btb_pkg::*; (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               flush,    // context switch, drops all lines
    input  grant_e             grant,
    input  logic [index_w-1:0] index,
    input  logic [tag_w-1:0]   tag,
    input  logic [addr_w-1:0]  wtarget,
    input  logic [addr_w-1:0]  wfip_e,
    input  logic [addr_w-1:0]  wfip_o,
    output logic               hit,
    output logic [addr_w-1:0]  rtarget,
    output logic [addr_w-1:0]  rfip_e,
    output logic [addr_w-1:0]  rfip_o
);

    // line storage
    logic [tag_w-1:0]  tag_mem    [btb_lines];
    logic [addr_w-1:0] target_mem [btb_lines];
    logic [addr_w-1:0] fip_e_mem  [btb_lines];
    logic [addr_w-1:0] fip_o_mem  [btb_lines];
    logic [btb_lines-1:0] valid;

    logic wr_en;
    logic tag_eq;

    assign wr_en = (grant == grant_update);

    // payload written on an update grant, valid bits track occupancy
    always_ff @(posedge clk) begin
        if (wr_en) begin
            tag_mem[index]    <= tag;
            target_mem[index] <= wtarget;
            fip_e_mem[index]  <= wfip_e;
            fip_o_mem[index]  <= wfip_o;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid <= '0;
        end else if (flush) begin
            valid <= '0;            // flush wins over a same cycle write
        end else if (wr_en) begin
            valid[index] <= 1'b1;
        end
    end

    // only the indexed line is compared, direct mapped
    assign tag_eq = (tag_mem[index] == tag);

    always_comb begin
        hit     = (grant == grant_lookup) && valid[index] && tag_eq;
        rtarget = target_mem[index];
        rfip_e  = fip_e_mem[index];
        rfip_o  = fip_o_mem[index];
    end

endmodule

/* src/btb_arbiter.sv */
module btb_arbiter import btb_pkg::*; (
    btb_port_if.arbiter        lookup,   // fetch side reads
    btb_port_if.arbiter        update,   // writeback side writes
    input  logic               full,     // update queue cannot take more
    output grant_e             grant,
    output logic [index_w-1:0] index,
    output logic [tag_w-1:0]   tag,
    output logic [addr_w-1:0]  wtarget,
    output logic [addr_w-1:0]  wfip_e,
    output logic [addr_w-1:0]  wfip_o,
    input  logic               hit,
    input  logic [addr_w-1:0]  rtarget,
    input  logic [addr_w-1:0]  rfip_e,
    input  logic [addr_w-1:0]  rfip_o
);

    logic lookup_rd;
    logic update_wr;

    assign lookup_rd = lookup.req && !lookup.we;
    assign update_wr = update.req && update.we;

    // fetch goes first unless a full queue must drain
    always_comb begin
        if (full && update_wr) begin
            grant = grant_update;
        end else if (lookup_rd) begin
            grant = grant_lookup;
        end else if (update_wr) begin
            grant = grant_update;
        end else begin
            grant = grant_none;
        end
    end

    // winner's fields go to the array
    always_comb begin
        index   = '0;
        tag     = '0;
        wtarget = '0;
        wfip_e  = '0;
        wfip_o  = '0;
        case (grant)
            grant_lookup: begin
                index   = lookup.index;
                tag     = lookup.tag;
                wtarget = lookup.wtarget;
                wfip_e  = lookup.wfip_e;
                wfip_o  = lookup.wfip_o;
            end
            grant_update: begin
                index   = update.index;
                tag     = update.tag;
                wtarget = update.wtarget;
                wfip_e  = update.wfip_e;
                wfip_o  = update.wfip_o;
            end
            default: ;
        endcase
    end

    // read results only go back to the owner
    assign lookup.gnt     = (grant == grant_lookup);
    assign lookup.hit     = lookup.gnt && hit;
    assign lookup.rtarget = lookup.gnt ? rtarget : '0;
    assign lookup.rfip_e  = lookup.gnt ? rfip_e : '0;
    assign lookup.rfip_o  = lookup.gnt ? rfip_o : '0;

    assign update.gnt     = (grant == grant_update);
    assign update.hit     = update.gnt && hit;
    assign update.rtarget = update.gnt ? rtarget : '0;
    assign update.rfip_e  = update.gnt ? rfip_e : '0;
    assign update.rfip_o  = update.gnt ? rfip_o : '0;

    // the port never idles while a requester is waiting
    always_comb begin
        if (lookup.req || update.req) begin
            assert (grant != grant_none)
                else $error("btb_arbiter: request left without a grant");
        end
    end

endmodule

/* src/btb_lookup.sv */
module btb_lookup import btb_pkg::*; (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              fetch_valid,  // one cycle strobe from fetch
    input  logic [addr_w-1:0] fetch_eip,
    btb_port_if.requester     port,
    output logic              pred_valid,   // follows fetch_valid by one cycle
    output logic              pred_hit,
    output logic [addr_w-1:0] pred_target,
    output logic [addr_w-1:0] pred_fip_e,
    output logic [addr_w-1:0] pred_fip_o
);

    // read only requester, write fields are never used by the array
    assign port.req     = fetch_valid;
    assign port.we      = 1'b0;
    assign port.index   = fetch_eip[index_w-1:0];
    assign port.tag     = fetch_eip[addr_w-1:index_w];
    assign port.wtarget = '0;
    assign port.wfip_e  = '0;
    assign port.wfip_o  = '0;

    logic hit_now;

    // losing arbitration is reported as a miss
    assign hit_now = fetch_valid && port.gnt && port.hit;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pred_valid <= 1'b0;
            pred_hit   <= 1'b0;
        end else begin
            pred_valid <= fetch_valid;
            pred_hit   <= hit_now;
        end
    end

    // prediction payload, only meaningful with pred_hit
    always_ff @(posedge clk) begin
        if (fetch_valid) begin
            pred_target <= port.rtarget;
            pred_fip_e  <= port.rfip_e;
            pred_fip_o  <= port.rfip_o;
        end
    end

endmodule

/* src/btb_update_queue.sv */
module btb_update_queue import btb_pkg::*; (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              flush,      // drops pending updates
    input  logic              wb_valid,   // resolved branch from writeback
    input  logic [addr_w-1:0] wb_eip,
    input  logic [addr_w-1:0] wb_target,
    input  logic [addr_w-1:0] wb_fip_e,
    input  logic [addr_w-1:0] wb_fip_o,
    btb_port_if.requester     port,
    output logic              full
);

    // entry storage
    logic [addr_w-1:0] eip_q    [queue_depth];
    logic [addr_w-1:0] target_q [queue_depth];
    logic [addr_w-1:0] fip_e_q  [queue_depth];
    logic [addr_w-1:0] fip_o_q  [queue_depth];

    logic [qptr_w-1:0] head;
    logic [qptr_w-1:0] tail;
    logic [qcnt_w-1:0] count;
    logic              empty;
    logic              push;
    logic              pop;

    assign empty = (count == '0);
    assign full  = (count == qcnt_w'(queue_depth));
    assign push  = wb_valid && !flush;
    assign pop   = port.gnt && !flush;

    // head entry is offered as a write while anything is queued
    assign port.req     = !empty;
    assign port.we      = 1'b1;
    assign port.index   = eip_q[head][index_w-1:0];
    assign port.tag     = eip_q[head][addr_w-1:index_w];
    assign port.wtarget = target_q[head];
    assign port.wfip_e  = fip_e_q[head];
    assign port.wfip_o  = fip_o_q[head];

    always_ff @(posedge clk) begin
        if (push) begin
            eip_q[tail]    <= wb_eip;
            target_q[tail] <= wb_target;
            fip_e_q[tail]  <= wb_fip_e;
            fip_o_q[tail]  <= wb_fip_o;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else if (flush) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (push) tail <= tail + qptr_w'(1);  // wraps at depth
            if (pop) head <= head + qptr_w'(1);
            case ({push, pop})
                2'b10:   count <= count + qcnt_w'(1);
                2'b01:   count <= count - qcnt_w'(1);
                default: count <= count;
            endcase
        end
    end

    // full queue gets the port, so a push always finds room
    a_no_overrun: assert property (@(posedge clk) disable iff (!arst_n)
        !(push && full && !pop))
        else $error("btb_update_queue: push while full without pop");

    a_no_underrun: assert property (@(posedge clk) disable iff (!arst_n)
        port.gnt |-> !empty)
        else $error("btb_update_queue: pop while empty");

endmodule

/* src/branch_target_buff.sv */
module branch_target_buff import btb_pkg::*; (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              flush,
    input  logic              fetch_valid,
    input  logic [addr_w-1:0] fetch_eip,
    input  logic              wb_valid,
    input  logic [addr_w-1:0] wb_eip,
    input  logic [addr_w-1:0] wb_target,
    input  logic [addr_w-1:0] wb_fip_e,
    input  logic [addr_w-1:0] wb_fip_o,
    output logic              pred_valid,
    output logic              pred_hit,
    output logic [addr_w-1:0] pred_target,
    output logic [addr_w-1:0] pred_fip_e,
    output logic [addr_w-1:0] pred_fip_o
);

    btb_port_if lookup_port ();
    btb_port_if update_port ();

    // arbiter to array
    grant_e             grant;
    logic               full;
    logic [index_w-1:0] index;
    logic [tag_w-1:0]   tag;
    logic [addr_w-1:0]  wtarget;
    logic [addr_w-1:0]  wfip_e;
    logic [addr_w-1:0]  wfip_o;
    logic               hit;
    logic [addr_w-1:0]  rtarget;
    logic [addr_w-1:0]  rfip_e;
    logic [addr_w-1:0]  rfip_o;

    btb_lookup u_lookup (
        .clk, .arst_n, .fetch_valid, .fetch_eip,
        .port(lookup_port.requester),
        .pred_valid, .pred_hit, .pred_target, .pred_fip_e, .pred_fip_o
    );

    btb_update_queue u_update_queue (
        .clk, .arst_n, .flush,
        .wb_valid, .wb_eip, .wb_target, .wb_fip_e, .wb_fip_o,
        .port(update_port.requester),
        .full
    );

    btb_arbiter u_arbiter (
        .lookup(lookup_port.arbiter),
        .update(update_port.arbiter),
        .full, .grant, .index, .tag, .wtarget, .wfip_e, .wfip_o,
        .hit, .rtarget, .rfip_e, .rfip_o
    );

    btb_array u_array (
        .clk, .arst_n, .flush, .grant, .index, .tag,
        .wtarget, .wfip_e, .wfip_o,
        .hit, .rtarget, .rfip_e, .rfip_o
    );

endmodule

/* testbench/tb_branch_target_buff.sv */
module tb_branch_target_buff import btb_pkg::*; ();

    logic              clk;
    logic              arst_n;
    logic              flush;
    logic              fetch_valid;
    logic [addr_w-1:0] fetch_eip;
    logic              wb_valid;
    logic [addr_w-1:0] wb_eip;
    logic [addr_w-1:0] wb_target;
    logic [addr_w-1:0] wb_fip_e;
    logic [addr_w-1:0] wb_fip_o;
    logic              pred_valid;
    logic              pred_hit;
    logic [addr_w-1:0] pred_target;
    logic [addr_w-1:0] pred_fip_e;
    logic [addr_w-1:0] pred_fip_o;

    integer seed = 90;
    int     err_valid = 0;
    int     err_hit = 0;
    int     err_payload = 0;
    int     err_timeout = 0;

    // reference model of committed lines and of writeback entries not yet known to be written
    logic              mdl_valid  [btb_lines];
    logic [tag_w-1:0]  mdl_tag    [btb_lines];
    logic [addr_w-1:0] mdl_target [btb_lines];
    logic [addr_w-1:0] mdl_fip_e  [btb_lines];
    logic [addr_w-1:0] mdl_fip_o  [btb_lines];
    logic [addr_w-1:0] pend_eip[$];
    logic [addr_w-1:0] pend_target[$];
    logic [addr_w-1:0] pend_fip_e[$];
    logic [addr_w-1:0] pend_fip_o[$];
    int                idle_cnt;

    // values captured at the falling edge and checked at the next rising edge
    logic              fetch_d = 1'b0;
    logic [addr_w-1:0] eip_d = '0;
    logic              got_valid = 1'b0;
    logic              exp_valid = 1'b0;
    logic              got_hit = 1'b0;
    logic              known = 1'b0;
    logic              must_hit = 1'b0;
    logic              vals_ok = 1'b0;
    logic [addr_w-1:0] got_target;
    logic [addr_w-1:0] got_fip_e;
    logic [addr_w-1:0] got_fip_o;
    logic [addr_w-1:0] exp_target;
    logic [addr_w-1:0] exp_fip_e;
    logic [addr_w-1:0] exp_fip_o;

    branch_target_buff dut (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic commit_pending();
        logic [index_w-1:0] idx;
        for (int i = 0; i < pend_eip.size(); i++) begin
            idx             = pend_eip[i][index_w-1:0];
            mdl_valid[idx]  = 1'b1;     // later entries overwrite earlier ones
            mdl_tag[idx]    = pend_eip[i][addr_w-1:index_w];
            mdl_target[idx] = pend_target[i];
            mdl_fip_e[idx]  = pend_fip_e[i];
            mdl_fip_o[idx]  = pend_fip_o[i];
        end
        pend_eip.delete();
        pend_target.delete();
        pend_fip_e.delete();
        pend_fip_o.delete();
    endtask

    task automatic clear_model();
        for (int i = 0; i < btb_lines; i++) mdl_valid[i] = 1'b0;
        pend_eip.delete();
        pend_target.delete();
        pend_fip_e.delete();
        pend_fip_o.delete();
        idle_cnt = 0;
    endtask

    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            clear_model();
        end else if (flush) begin
            clear_model();              // same cycle writeback is dropped too
        end else begin
            if (wb_valid) begin
                pend_eip.push_back(wb_eip);
                pend_target.push_back(wb_target);
                pend_fip_e.push_back(wb_fip_e);
                pend_fip_o.push_back(wb_fip_o);
            end
            if (fetch_valid || wb_valid) begin
                idle_cnt = 0;
            end else if (pend_eip.size() != 0) begin
                idle_cnt++;
                if (idle_cnt == 4) begin  // queue has drained by now
                    commit_pending();
                    idle_cnt = 0;
                end
            end
        end
    end

    // decides which results are acceptable for the lookup of eip_d
    task automatic score_prediction();
        logic [index_w-1:0] idx;
        logic               in_model;
        idx      = eip_d[index_w-1:0];
        in_model = mdl_valid[idx] && (mdl_tag[idx] == eip_d[addr_w-1:index_w]);
        must_hit = in_model && (pend_eip.size() == 0);
        known    = in_model;
        vals_ok  = 1'b0;
        if (in_model) begin
            exp_target = mdl_target[idx];
            exp_fip_e  = mdl_fip_e[idx];
            exp_fip_o  = mdl_fip_o[idx];
            vals_ok    = (got_target == exp_target) && (got_fip_e == exp_fip_e) &&
                         (got_fip_o == exp_fip_o);
        end
        for (int i = 0; i < pend_eip.size(); i++) begin
            if (pend_eip[i] == eip_d) begin
                known      = 1'b1;
                exp_target = pend_target[i];
                exp_fip_e  = pend_fip_e[i];
                exp_fip_o  = pend_fip_o[i];
                if ((got_target == exp_target) && (got_fip_e == exp_fip_e) &&
                    (got_fip_o == exp_fip_o)) vals_ok = 1'b1;
            end
        end
    endtask

    always @(negedge clk) begin
        got_valid  = pred_valid;
        exp_valid  = fetch_d;          // pred_valid follows fetch_valid by one cycle
        got_hit    = pred_hit;
        got_target = pred_target;
        got_fip_e  = pred_fip_e;
        got_fip_o  = pred_fip_o;
        known      = 1'b0;
        must_hit   = 1'b0;
        vals_ok    = 1'b0;
        if (pred_valid) score_prediction();
        fetch_d = fetch_valid;
        eip_d   = fetch_eip;
    end

    task automatic report_payload();
        if (got_target != exp_target)
            $display("mismatch pred_target: got %h expected %h", got_target, exp_target);
        if (got_fip_e != exp_fip_e)
            $display("mismatch pred_fip_e: got %h expected %h", got_fip_e, exp_fip_e);
        if (got_fip_o != exp_fip_o)
            $display("mismatch pred_fip_o: got %h expected %h", got_fip_o, exp_fip_o);
    endtask

    a_latency: assert property (@(posedge clk) disable iff (!arst_n) got_valid == exp_valid)
        else begin
            err_valid++;
            $display("mismatch pred_valid: got %h expected %h", got_valid, exp_valid);
        end

    a_false_hit: assert property (@(posedge clk) disable iff (!arst_n)
        !(got_valid && got_hit && !known))
        else begin
            err_hit++;
            $display("mismatch pred_hit: got %h expected %h", got_hit, 1'b0);
        end

    a_lost_hit: assert property (@(posedge clk) disable iff (!arst_n)
        !(got_valid && !got_hit && must_hit))
        else begin
            err_hit++;
            $display("mismatch pred_hit: got %h expected %h", got_hit, 1'b1);
        end

    a_payload: assert property (@(posedge clk) disable iff (!arst_n)
        !(got_valid && got_hit && known && !vals_ok))
        else begin
            err_payload++;
            report_payload();
        end

    function automatic logic [addr_w-1:0] rand_word();
        return $random(seed);
    endfunction

    task automatic note_timeout(input string why);
        err_timeout++;
        $display("%s", why);
    endtask

    task automatic wait_pred();
        int n;
        n = 0;
        @(negedge clk);
        while (!pred_valid && n < 4) begin
            @(negedge clk);
            n++;
        end
        if (!pred_valid) note_timeout("timeout waiting for pred_valid after a lookup");
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        @(negedge clk);
        while (pend_eip.size() != 0 && n < 20) begin
            @(negedge clk);
            n++;
        end
        if (pend_eip.size() != 0) note_timeout("timeout waiting for the update queue to drain");
    endtask

    task automatic fetch_lookup(input logic [addr_w-1:0] eip);
        @(posedge clk);
        fetch_valid <= 1'b1;
        fetch_eip   <= eip;
        @(posedge clk);
        fetch_valid <= 1'b0;
        wait_pred();
    endtask

    task automatic write_branch(input logic [addr_w-1:0] eip);
        @(posedge clk);
        wb_valid  <= 1'b1;
        wb_eip    <= eip;
        wb_target <= rand_word();
        wb_fip_e  <= rand_word();
        wb_fip_o  <= rand_word();
        @(posedge clk);
        wb_valid  <= 1'b0;
    endtask

    initial begin
        logic [addr_w-1:0] eip_a;
        logic [addr_w-1:0] eip_b;
        logic [addr_w-1:0] r;
        logic [addr_w-1:0] burst_eip [6];
        logic [addr_w-1:0] pool [8];
        arst_n = 1'b0;
        flush = 1'b0;
        fetch_valid = 1'b0;
        fetch_eip = '0;
        wb_valid = 1'b0;
        wb_eip = '0;
        wb_target = '0;
        wb_fip_e = '0;
        wb_fip_o = '0;
        repeat (8) @(posedge clk);
        arst_n <= 1'b1;

        for (int k = 0; k < 8; k++) fetch_lookup(rand_word());  // empty buffer misses

        r = rand_word();
        eip_a = {r[addr_w-1:index_w], index_w'(1)};
        write_branch(eip_a);
        wait_drain();
        fetch_lookup(eip_a);

        eip_b = {eip_a[addr_w-1:index_w] ^ tag_w'(1), eip_a[index_w-1:0]};  // same line
        fetch_lookup(eip_b);
        write_branch(eip_b);
        wait_drain();
        fetch_lookup(eip_b);
        fetch_lookup(eip_a);

        for (int k = 0; k < 6; k++) begin
            r = rand_word();
            burst_eip[k] = {r[addr_w-1:index_w], index_w'(k + 8)};
        end
        for (int k = 0; k < 10; k++) begin      // writeback burst under continuous fetch
            @(posedge clk);
            fetch_valid <= 1'b1;
            fetch_eip   <= burst_eip[k % 6];
            wb_valid    <= (k < 6);
            wb_eip      <= burst_eip[k % 6];
            wb_target   <= rand_word();
            wb_fip_e    <= rand_word();
            wb_fip_o    <= rand_word();
        end
        @(posedge clk);
        fetch_valid <= 1'b0;
        wb_valid    <= 1'b0;
        wait_pred();
        wait_drain();
        for (int k = 0; k < 6; k++) fetch_lookup(burst_eip[k]);

        @(posedge clk);
        flush <= 1'b1;
        @(posedge clk);
        flush <= 1'b0;
        fetch_lookup(eip_b);
        for (int k = 0; k < 6; k++) fetch_lookup(burst_eip[k]);

        for (int k = 0; k < 8; k++) begin
            r = rand_word();
            pool[k] = {r[addr_w-1:index_w], index_w'(k + 32)};
        end
        for (int k = 0; k < 300; k++) begin
            r = rand_word();
            @(posedge clk);
            fetch_valid <= r[0];
            fetch_eip   <= pool[r[3:1]];
            wb_valid    <= r[4] & r[5];
            wb_eip      <= pool[r[8:6]];
            wb_target   <= rand_word();
            wb_fip_e    <= rand_word();
            wb_fip_o    <= rand_word();
        end
        @(posedge clk);
        fetch_valid <= 1'b0;
        wb_valid    <= 1'b0;
        wait_drain();
        for (int k = 0; k < 8; k++) fetch_lookup(pool[k]);

        repeat (3) @(posedge clk);
        $display("errors: pred_valid %0d, pred_hit %0d, payload %0d, timeout %0d",
                 err_valid, err_hit, err_payload, err_timeout);
        if (err_valid + err_hit + err_payload + err_timeout == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

/* verilog.f */
src/btb_pkg.sv
src/btb_port_if.sv
src/btb_array.sv
src/btb_arbiter.sv
src/btb_lookup.sv
src/btb_update_queue.sv
src/branch_target_buff.sv
testbench/tb_branch_target_buff.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the testbench with Verilator, runs it and checks the log
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module tb_branch_target_buff \
    -f verilog.f \
    -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -qF "*** TEST FAILED ***" sim.log; then
    echo "simulation reported failure"
    exit 1
fi
echo "simulation finished without failure"
